//--- design/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// Receiver ticks per serial bit.
`define UART_OVERSAMPLE 16

// System clocks per oversampling tick.
`define UART_BAUD_DIV 4

// Receive FIFO entries.
`define UART_FIFO_DEPTH 4

// Fill level at which RTS asks the far end to stop.
`define UART_FIFO_HIGH 3

`endif

//--- design/uart_pkg.sv
package uart_pkg;

	// Line configuration.
	// data_bits 0 selects 5 data bits, 3 selects 8.
	typedef struct packed {
		logic       parity_en;
		logic       parity_odd;
		logic       two_stop;
		logic [1:0] data_bits;
	} uart_cfg_t;

	// One received character with its error flags.
	// Data is right-aligned, the unused upper bits read as zero.
	typedef struct packed {
		logic [7:0] data;
		logic       parity_err;
		logic       stop_err;
	} rx_frame_t;

endpackage

//--- design/rx_line_frontend.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module rx_line_frontend (
	input  logic clk,
	input  logic reset_n,
	input  logic rx_i,
	output logic tick_o,
	output logic rx_sync_o,
	output logic start_edge_o
);

	localparam int DIV_W = (`UART_BAUD_DIV > 1) ? $clog2(`UART_BAUD_DIV) : 1;
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`UART_BAUD_DIV - 1);

	logic [DIV_W-1:0] div_cnt;
	logic             sync_meta;
	logic             sync_q;
	logic             sync_prev;

	// Free running baud divider.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			div_cnt <= '0;
		end else if (div_cnt == DIV_LAST) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign tick_o = (div_cnt == DIV_LAST);

	// Line idles high, so reset to one to avoid a false start edge.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			sync_meta <= 1'b1;
			sync_q    <= 1'b1;
			sync_prev <= 1'b1;
		end else begin
			sync_meta <= rx_i;
			sync_q    <= sync_meta;
			sync_prev <= sync_q;
		end
	end

	assign rx_sync_o = sync_q;

	// High to low on the synchronized line.
	assign start_edge_o = sync_prev & ~sync_q;

endmodule

//--- design/rx_controller.sv
`timescale 1ns/1ps

module rx_controller (
	input  logic clk,
	input  logic reset_n,
	input  logic start_edge_i,
	input  logic bit_mid_i,
	input  logic rx_sync_i,
	input  logic last_data_i,
	input  logic frame_end_i,
	input  logic rx_en_i,
	input  logic rts_ni,
	input  logic parity_en_i,
	output logic busy_o,
	output logic in_data_o,
	output logic in_parity_o,
	output logic in_stop_o,
	output logic frame_done_o
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_START,
		ST_DATA,
		ST_PARITY,
		ST_STOP
	} state_t;

	state_t state;
	state_t state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				// New frames only while enabled and RTS says ready.
				if (start_edge_i && rx_en_i && !rts_ni) begin
					state_nxt = ST_START;
				end
			end
			ST_START: begin
				// A high line at mid start bit was a glitch.
				if (bit_mid_i) begin
					state_nxt = rx_sync_i ? ST_IDLE : ST_DATA;
				end
			end
			ST_DATA: begin
				if (bit_mid_i && last_data_i) begin
					state_nxt = parity_en_i ? ST_PARITY : ST_STOP;
				end
			end
			ST_PARITY: begin
				if (bit_mid_i) begin
					state_nxt = ST_STOP;
				end
			end
			ST_STOP: begin
				if (bit_mid_i && frame_end_i) begin
					state_nxt = ST_IDLE;
				end
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	assign busy_o       = (state != ST_IDLE);
	assign in_data_o    = (state == ST_DATA);
	assign in_parity_o  = (state == ST_PARITY);
	assign in_stop_o    = (state == ST_STOP);
	assign frame_done_o = (state == ST_STOP) && bit_mid_i && frame_end_i;

endmodule

//--- design/uart_receiver.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_receiver import uart_pkg::*; (
	input  logic      clk,
	input  logic      reset_n,
	input  logic      tick_i,
	input  logic      rx_sync_i,
	input  logic      start_edge_i,
	input  logic      rx_en_i,
	input  logic      rts_ni,
	input  uart_cfg_t cfg_i,
	output logic      frame_wr_o,
	output rx_frame_t frame_o
);

	localparam int OS_W = $clog2(`UART_OVERSAMPLE);
	localparam logic [OS_W-1:0] OS_MID = OS_W'(`UART_OVERSAMPLE / 2 - 1);

	uart_cfg_t       cfg_q;
	logic [OS_W-1:0] tick_cnt;
	logic [2:0]      bit_cnt;
	logic            stop_cnt;
	logic [7:0]      shift_q;
	logic            par_q;
	logic            stop_err_q;
	logic [2:0]      align_sh;
	logic [7:0]      data_aligned;
	logic            parity_err;
	logic            busy;
	logic            in_data;
	logic            in_parity;
	logic            in_stop;
	logic            frame_done;
	logic            bit_mid;
	logic            last_data;
	logic            frame_end;

	// Config follows the input while idle and freezes once a frame starts.
	always_ff @(posedge clk) begin
		if (!busy) begin
			cfg_q <= cfg_i;
		end
	end

	// Oversample counter, held at zero until a frame is accepted.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			tick_cnt <= '0;
		end else if (!busy) begin
			tick_cnt <= '0;
		end else if (tick_i) begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	assign bit_mid = busy && tick_i && (tick_cnt == OS_MID);

	// Data and stop bit counters.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			bit_cnt  <= '0;
			stop_cnt <= 1'b0;
		end else if (!busy) begin
			bit_cnt  <= '0;
			stop_cnt <= 1'b0;
		end else if (bit_mid) begin
			if (in_data) begin
				bit_cnt <= bit_cnt + 1'b1;
			end
			if (in_stop) begin
				stop_cnt <= 1'b1;
			end
		end
	end

	assign last_data = (bit_cnt == ({1'b0, cfg_q.data_bits} + 3'd4));
	assign frame_end = !cfg_q.two_stop || stop_cnt;

	// LSB first, so a short character ends up in the upper bits.
	always_ff @(posedge clk) begin
		if (bit_mid && in_data) begin
			shift_q <= {rx_sync_i, shift_q[7:1]};
		end
		if (bit_mid && in_parity) begin
			par_q <= rx_sync_i;
		end
	end

	assign align_sh     = 3'd3 - {1'b0, cfg_q.data_bits};
	assign data_aligned = shift_q >> align_sh;
	assign parity_err   = cfg_q.parity_en && ((^data_aligned ^ par_q) != cfg_q.parity_odd);

	// Sticky over both stop bits.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			stop_err_q <= 1'b0;
		end else if (!busy) begin
			stop_err_q <= 1'b0;
		end else if (bit_mid && in_stop && !rx_sync_i) begin
			stop_err_q <= 1'b1;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			frame_wr_o <= 1'b0;
			frame_o    <= '0;
		end else begin
			frame_wr_o <= frame_done;
			if (frame_done) begin
				frame_o.data       <= data_aligned;
				frame_o.parity_err <= parity_err;
				frame_o.stop_err   <= stop_err_q | ~rx_sync_i;
			end
		end
	end

	rx_controller u_rx_controller (
		.clk          (clk),
		.reset_n      (reset_n),
		.start_edge_i (start_edge_i),
		.bit_mid_i    (bit_mid),
		.rx_sync_i    (rx_sync_i),
		.last_data_i  (last_data),
		.frame_end_i  (frame_end),
		.rx_en_i      (rx_en_i),
		.rts_ni       (rts_ni),
		.parity_en_i  (cfg_q.parity_en),
		.busy_o       (busy),
		.in_data_o    (in_data),
		.in_parity_o  (in_parity),
		.in_stop_o    (in_stop),
		.frame_done_o (frame_done)
	);

endmodule

//--- design/rx_fifo.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module rx_fifo import uart_pkg::*; (
	input  logic      clk,
	input  logic      reset_n,
	input  logic      wr_i,
	input  logic      rd_i,
	input  rx_frame_t wr_frame_i,
	output rx_frame_t rd_frame_o,
	output logic      valid_o,
	output logic      rts_no,
	output logic      overflow_o
);

	localparam int DEPTH = `UART_FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

	rx_frame_t        mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fill_cnt;
	logic [CNT_W-1:0] fill_nxt;
	logic             full;
	logic             push;
	logic             pop;

	assign full = (fill_cnt == CNT_W'(DEPTH));
	assign push = wr_i && !full;
	assign pop  = rd_i && valid_o;

	always_comb begin
		fill_nxt = fill_cnt;
		if (push && !pop) begin
			fill_nxt = fill_cnt + 1'b1;
		end else if (pop && !push) begin
			fill_nxt = fill_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wr_frame_i;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fill_cnt   <= '0;
			rts_no     <= 1'b0;
			overflow_o <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
			end
			fill_cnt <= fill_nxt;
			// Stop the sender before the last free entry is used.
			rts_no     <= (fill_nxt >= CNT_W'(`UART_FIFO_HIGH));
			overflow_o <= wr_i && full;
		end
	end

	assign valid_o    = (fill_cnt != '0);
	assign rd_frame_o = mem[rd_ptr];

endmodule

//--- design/uart_rx_top.sv
`timescale 1ns/1ps

module uart_rx_top import uart_pkg::*; (
	input  logic      clk,
	input  logic      reset_n,
	input  logic      rx_i,
	input  logic      rx_en_i,
	input  logic      rd_i,
	input  uart_cfg_t cfg_i,
	output rx_frame_t frame_o,
	output logic      valid_o,
	output logic      rts_no,
	output logic      overflow_o
);

	logic      tick;
	logic      rx_sync;
	logic      start_edge;
	logic      frame_wr;
	rx_frame_t wr_frame;

	rx_line_frontend u_rx_line_frontend (
		.clk          (clk),
		.reset_n      (reset_n),
		.rx_i         (rx_i),
		.tick_o       (tick),
		.rx_sync_o    (rx_sync),
		.start_edge_o (start_edge)
	);

	// RTS also holds off new frames in the receiver.
	uart_receiver u_uart_receiver (
		.clk          (clk),
		.reset_n      (reset_n),
		.tick_i       (tick),
		.rx_sync_i    (rx_sync),
		.start_edge_i (start_edge),
		.rx_en_i      (rx_en_i),
		.rts_ni       (rts_no),
		.cfg_i        (cfg_i),
		.frame_wr_o   (frame_wr),
		.frame_o      (wr_frame)
	);

	rx_fifo u_rx_fifo (
		.clk        (clk),
		.reset_n    (reset_n),
		.wr_i       (frame_wr),
		.rd_i       (rd_i),
		.wr_frame_i (wr_frame),
		.rd_frame_o (frame_o),
		.valid_o    (valid_o),
		.rts_no     (rts_no),
		.overflow_o (overflow_o)
	);

endmodule

//--- sim/uart_rx_asserts.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_rx_asserts import uart_pkg::*; (
	input logic      clk,
	input logic      reset_n,
	input logic      rd_i,
	input logic      wr_i,
	input logic      valid_i,
	input logic      rts_ni,
	input logic      overflow_i,
	input rx_frame_t frame_i
);

	localparam int DEPTH = `UART_FIFO_DEPTH;
	localparam int HIGH  = `UART_FIFO_HIGH;

	int held;

	// Frames held in the FIFO, counted from the write and read strobes.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			held <= 0;
		end else begin
			held <= held + ((wr_i && held < DEPTH) ? 1 : 0) - ((rd_i && held > 0) ? 1 : 0);
		end
	end

	// Outputs are quiet on the first edge after reset is released.
	reset_quiet: assert property (@(posedge clk)
		$rose(reset_n) |-> (!valid_i && !rts_ni && !overflow_i))
	else begin
		$error("valid_o, rts_no or overflow_o was not low right after reset");
		uart_rx_tb.assert_errs = uart_rx_tb.assert_errs + 1;
	end

	// Nearly full FIFO must hold off the sender.
	rts_level: assert property (@(posedge clk) disable iff (!reset_n)
		(held >= HIGH) |-> rts_ni)
	else begin
		$error("rts_no is low while the FIFO holds %0d frames", $sampled(held));
		uart_rx_tb.assert_errs = uart_rx_tb.assert_errs + 1;
	end

	pop_expected: assert property (@(posedge clk) disable iff (!reset_n)
		(rd_i && valid_i) |-> uart_rx_tb.exp_valid)
	else begin
		$error("%s: a frame was popped while none was expected", uart_rx_tb.test_name);
		uart_rx_tb.assert_errs = uart_rx_tb.assert_errs + 1;
	end

	// Popped frame against the head of the reference queue.
	frame_match: assert property (@(posedge clk) disable iff (!reset_n)
		(rd_i && valid_i && uart_rx_tb.exp_valid) |-> (frame_i == uart_rx_tb.exp_head))
	else begin
		$error("mismatch %s expected %h actual %h", uart_rx_tb.test_name,
			$sampled(uart_rx_tb.exp_head), $sampled(frame_i));
		uart_rx_tb.assert_errs = uart_rx_tb.assert_errs + 1;
	end

endmodule

//--- sim/uart_rx_tb.sv
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_rx_tb import uart_pkg::*; ();

	localparam int CLK_NS = 4;
	localparam int BIT_CLKS = `UART_BAUD_DIV * `UART_OVERSAMPLE;
	localparam int N_FRAMES = 23;
	localparam int WATCHDOG_NS = N_FRAMES * 12 * BIT_CLKS * CLK_NS * 2;

	logic      clk;
	logic      reset_n;
	logic      rx_i;
	logic      rx_en_i;
	logic      rd_i;
	uart_cfg_t cfg_i;
	rx_frame_t frame_o;
	logic      valid_o;
	logic      rts_no;
	logic      overflow_o;

	// Reference queue head, read by the bound checker.
	rx_frame_t exp_q[$];
	rx_frame_t exp_head;
	logic      exp_valid;
	string     test_name;
	int        assert_errs;
	int        tb_errs;
	int        tests_run;
	int        tests_failed;
	int        errs_at_start;

	uart_rx_top u_uart_rx_top (
		.clk        (clk),
		.reset_n    (reset_n),
		.rx_i       (rx_i),
		.rx_en_i    (rx_en_i),
		.rd_i       (rd_i),
		.cfg_i      (cfg_i),
		.frame_o    (frame_o),
		.valid_o    (valid_o),
		.rts_no     (rts_no),
		.overflow_o (overflow_o)
	);

	bind uart_rx_top uart_rx_asserts u_uart_rx_asserts (
		.clk        (clk),
		.reset_n    (reset_n),
		.rd_i       (rd_i),
		.wr_i       (frame_wr),
		.valid_i    (valid_o),
		.rts_ni     (rts_no),
		.overflow_i (overflow_o),
		.frame_i    (frame_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run is stuck in %s", WATCHDOG_NS, test_name);
		$display("STATUS: FAIL");
		$finish;
	end

	function automatic void refresh_head();
		exp_valid = (exp_q.size() > 0);
		exp_head  = exp_valid ? exp_q[0] : '0;
	endfunction

	task automatic drive_bit(input logic level);
		rx_i = level;
		repeat (BIT_CLKS) @(posedge clk);
		#1;
	endtask

	// Serializes one character in the current configuration, LSB first.
	task automatic send_frame(input logic flip_par, input logic low_stop2);
		logic [7:0] data;
		logic       par;
		int         width;
		rx_frame_t  exp;
		data  = 8'($urandom) & (8'hFF >> (2'd3 - cfg_i.data_bits));
		width = int'(cfg_i.data_bits) + 5;
		par   = ^data ^ cfg_i.parity_odd ^ flip_par;
		exp.data       = data;
		exp.parity_err = flip_par & cfg_i.parity_en;
		exp.stop_err   = low_stop2 & cfg_i.two_stop;
		rx_i = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		if (rx_en_i && !rts_no) begin
			exp_q.push_back(exp);
			refresh_head();
		end
		drive_bit(1'b0);
		for (int i = 0; i < width; i++) begin
			drive_bit(data[i]);
		end
		if (cfg_i.parity_en) begin
			drive_bit(par);
		end
		drive_bit(1'b1);
		// Second stop position, plain idle when only one stop bit is configured.
		drive_bit(!low_stop2);
		rx_i = 1'b1;
	endtask

	task automatic pop_frame();
		rd_i = 1'b1;
		@(posedge clk);
		#1;
		rd_i = 1'b0;
		if (exp_q.size() > 0) begin
			void'(exp_q.pop_front());
		end
		refresh_head();
	endtask

	task automatic drain();
		int waited;
		while (exp_q.size() > 0) begin
			waited = 0;
			while (!valid_o && waited < 2 * BIT_CLKS) begin
				@(posedge clk);
				#1;
				waited++;
			end
			if (valid_o) begin
				pop_frame();
			end else begin
				$display("%s: an expected frame was never received", test_name);
				tb_errs++;
				exp_q.delete();
				refresh_head();
			end
		end
		// Popping a leftover frame trips the compare check.
		while (valid_o) begin
			pop_frame();
		end
	endtask

	task automatic begin_test(input string name);
		test_name     = name;
		errs_at_start = tb_errs + assert_errs;
	endtask

	task automatic end_test();
		int errs;
		errs = tb_errs + assert_errs - errs_at_start;
		tests_run++;
		if (errs == 0) begin
			$display("test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", test_name, errs);
		end
	endtask

	initial begin
		void'($urandom(1));
		reset_n      = 1'b0;
		rx_i         = 1'b1;
		rx_en_i      = 1'b1;
		rd_i         = 1'b0;
		cfg_i        = '{1'b0, 1'b0, 1'b0, 2'd3};
		assert_errs  = 0;
		tb_errs      = 0;
		tests_run    = 0;
		tests_failed = 0;
		test_name    = "reset";
		exp_q.delete();
		refresh_head();
		repeat (4) @(posedge clk);
		#1;
		reset_n = 1'b1;
		repeat (4) @(posedge clk);
		#1;

		// Pairs are held in the FIFO so that read order is checked.
		begin_test("data_8n1");
		for (int i = 0; i < 4; i++) begin
			send_frame(1'b0, 1'b0);
			send_frame(1'b0, 1'b0);
			drain();
		end
		end_test();

		begin_test("widths");
		for (int w = 0; w < 3; w++) begin
			cfg_i = '{1'b0, 1'b0, 1'b0, 2'(w)};
			send_frame(1'b0, 1'b0);
			drain();
		end
		end_test();

		begin_test("parity");
		cfg_i = '{1'b1, 1'b0, 1'b0, 2'd3};
		send_frame(1'b0, 1'b0);
		drain();
		cfg_i = '{1'b1, 1'b1, 1'b0, 2'd3};
		send_frame(1'b0, 1'b0);
		drain();
		send_frame(1'b1, 1'b0);
		drain();
		end_test();

		begin_test("stop_bits");
		cfg_i = '{1'b0, 1'b0, 1'b1, 2'd3};
		send_frame(1'b0, 1'b1);
		drain();
		cfg_i = '{1'b0, 1'b0, 1'b0, 2'd3};
		send_frame(1'b0, 1'b0);
		drain();
		end_test();

		begin_test("rx_disabled");
		rx_en_i = 1'b0;
		send_frame(1'b0, 1'b0);
		send_frame(1'b0, 1'b0);
		drain();
		rx_en_i = 1'b1;
		end_test();

		begin_test("flow_control");
		send_frame(1'b0, 1'b0);
		if (!valid_o) begin
			$display("flow_control: valid_o did not rise for the first frame");
			tb_errs++;
		end
		repeat (`UART_FIFO_HIGH - 1) send_frame(1'b0, 1'b0);
		if (!rts_no) begin
			$display("flow_control: rts_no stayed low with %0d frames held", `UART_FIFO_HIGH);
			tb_errs++;
		end
		send_frame(1'b0, 1'b0);
		drain();
		if (rts_no) begin
			$display("flow_control: rts_no still high after the FIFO was drained");
			tb_errs++;
		end
		send_frame(1'b0, 1'b0);
		drain();
		end_test();

		$display("tests run %0d, tests failed %0d, errors %0d",
			tests_run, tests_failed, tb_errs + assert_errs);
		if (tests_failed == 0 && tb_errs + assert_errs == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- files.f
+incdir+design
design/uart_pkg.sv
design/rx_line_frontend.sv
design/rx_controller.sv
design/uart_receiver.sv
design/rx_fifo.sv
design/uart_rx_top.sv
sim/uart_rx_asserts.sv
sim/uart_rx_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the UART receiver testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f files.f --top-module uart_rx_tb -Mdir "$OBJ"
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

# Let every assertion failure be reported instead of stopping at the first.
"./$OBJ/Vuart_rx_tb" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
